//--- run.sh
#!/bin/sh
# build and run the wb2sdrc testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_wb2sdrc -Mdir obj_dir -f sim.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/Vtb_wb2sdrc)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulator exited with status $status"
	exit 1
fi

if echo "$out" | grep -qx "Simulation passed"; then
	exit 0
fi
exit 1

//--- sim.f
source/wb2sdrc_pkg.sv
source/show_ahead_fifo.sv
source/wb_slave_ctrl.sv
source/wb2sdrc.sv
tb/sdr_ctrl_model.sv
tb/tb_wb2sdrc.sv

//--- source/show_ahead_fifo.sv
`default_nettype none

module show_ahead_fifo #(
	parameter int W     = 32,
	parameter int DEPTH = 4
) (
	input  logic         sdram_clk,
	input  logic         wb_clk_i,

	// push side
	input  logic         push_i,
	input  logic [W-1:0] push_data_i,
	output logic         full_o,

	// pop side, head word always on pop_data_o
	input  logic         pop_i,
	output logic [W-1:0] pop_data_o,
	output logic         empty_o
);

	// pointer width, at least one bit even for a single entry
	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	// count must reach DEPTH itself
	localparam int CW = $clog2(DEPTH + 1);

	// ------------------------------------------------------------------------
	// storage and state
	// ------------------------------------------------------------------------
	logic [W-1:0]  mem [DEPTH];
	logic [AW-1:0] wr_ptr_q;
	logic [AW-1:0] rd_ptr_q;
	logic [CW-1:0] count_q;
	logic [CW-1:0] count_next;
	logic          full_q;
	logic          empty_q;

	// qualified strobes
	logic          do_push;
	logic          do_pop;

	// an illegal strobe leaves the contents alone
	assign do_push = push_i & ~full_q;
	assign do_pop  = pop_i & ~empty_q;

	// ------------------------------------------------------------------------
	// occupancy
	// ------------------------------------------------------------------------
	always_comb begin
		case ({do_push, do_pop})
			2'b10:   count_next = count_q + 1'b1;
			2'b01:   count_next = count_q - 1'b1;
			// both or neither, level unchanged
			default: count_next = count_q;
		endcase
	end

	always_ff @(posedge sdram_clk or posedge wb_clk_i) begin
		if (wb_clk_i) begin
			count_q <= '0;
			full_q  <= 1'b0;
			empty_q <= 1'b1;
		end else begin
			count_q <= count_next;
			// flags registered from the next count
			full_q  <= (count_next == CW'(DEPTH));
			empty_q <= (count_next == '0);
		end
	end

	// ------------------------------------------------------------------------
	// pointers, wrap at DEPTH so odd depths work too
	// ------------------------------------------------------------------------
	always_ff @(posedge sdram_clk or posedge wb_clk_i) begin
		if (wb_clk_i) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
		end else begin
			if (do_push) begin
				wr_ptr_q <= (wr_ptr_q == AW'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
			end
			if (do_pop) begin
				rd_ptr_q <= (rd_ptr_q == AW'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
			end
		end
	end

	// write port
	always_ff @(posedge sdram_clk) begin
		if (do_push) begin
			mem[wr_ptr_q] <= push_data_i;
		end
	end

	// ------------------------------------------------------------------------
	// outputs
	// ------------------------------------------------------------------------
	// head word, valid whenever empty_o is low
	assign pop_data_o = mem[rd_ptr_q];
	assign full_o     = full_q;
	assign empty_o    = empty_q;

	// ------------------------------------------------------------------------
	// checks
	// ------------------------------------------------------------------------
	// writer must honour full
	a_no_overflow: assert property (
		@(posedge sdram_clk) disable iff (wb_clk_i)
		!(push_i && full_o)
	) else $error("%m fifo push while full");

	// reader must honour empty
	a_no_underflow: assert property (
		@(posedge sdram_clk) disable iff (wb_clk_i)
		!(pop_i && empty_o)
	) else $error("%m fifo pop while empty");

endmodule

`default_nettype wire

//--- source/wb2sdrc.sv
`default_nettype none

module wb2sdrc #(
	parameter int DW     = wb2sdrc_pkg::DEF_DW,
	parameter int APP_AW = wb2sdrc_pkg::DEF_APP_AW,
	parameter int BL     = wb2sdrc_pkg::DEF_BL
) (
	input  logic                sdram_clk,
	input  logic                wb_clk_i,

	// wishbone slave
	input  logic                wb_stb_i,
	input  logic                wb_cyc_i,
	input  logic                wb_we_i,
	input  logic [APP_AW-1:0]   wb_addr_i,
	input  logic [DW-1:0]       wb_dat_i,
	input  logic [DW/8-1:0]     wb_sel_i,
	output logic                wb_ack_o,
	output logic [DW-1:0]       wb_dat_o,

	// controller requests
	output logic                sdr_req_o,
	output logic [APP_AW-1:0]   sdr_req_addr_o,
	output logic [BL-1:0]       sdr_req_len_o,
	// low for write, high for read
	output logic                sdr_req_wr_n_o,
	input  logic                sdr_req_ack_i,

	// controller write data
	output logic [DW/8-1:0]     sdr_wr_en_n_o,
	output logic [DW-1:0]       sdr_wr_data_o,
	input  logic                sdr_wr_next_i,

	// controller read data
	input  logic                sdr_rd_valid_i,
	input  logic [DW-1:0]       sdr_rd_data_i
);

	import wb2sdrc_pkg::*;

	// queue word widths
	// opcode above the address
	localparam int CMD_W   = APP_AW + 1;
	// active low byte mask above the data
	localparam int WRDAT_W = DW / 8 + DW;

	// ------------------------------------------------------------------------
	// internal nets
	// ------------------------------------------------------------------------
	// strobes from the slave control
	logic               cmd_push;
	sdr_op_e            cmd_op;
	logic               wrdat_push;
	logic               rddat_pop;

	// queue status
	logic               cmd_full;
	logic               cmd_empty;
	logic               wrdat_full;
	logic               wrdat_empty;
	logic               rddat_empty;

	// queue heads
	logic [CMD_W-1:0]   cmd_head;
	logic [WRDAT_W-1:0] wrdat_head;

	// ------------------------------------------------------------------------
	// wishbone acknowledge and queue strobes
	// ------------------------------------------------------------------------
	wb_slave_ctrl u_slave_ctrl (
		.sdram_clk     (sdram_clk),
		.wb_clk_i      (wb_clk_i),
		.wb_stb_i      (wb_stb_i),
		.wb_cyc_i      (wb_cyc_i),
		.wb_we_i       (wb_we_i),
		.cmd_full_i    (cmd_full),
		.wrdat_full_i  (wrdat_full),
		.rddat_empty_i (rddat_empty),
		.wb_ack_o      (wb_ack_o),
		.cmd_push_o    (cmd_push),
		.cmd_op_o      (cmd_op),
		.wrdat_push_o  (wrdat_push),
		.rddat_pop_o   (rddat_pop)
	);

	// ------------------------------------------------------------------------
	// command queue
	// ------------------------------------------------------------------------
	// popped by the controller's request ack
	show_ahead_fifo #(.W(CMD_W), .DEPTH(CMD_DEPTH)) u_cmdfifo (
		.sdram_clk   (sdram_clk),
		.wb_clk_i    (wb_clk_i),
		.push_i      (cmd_push),
		.push_data_i ({cmd_op, wb_addr_i}),
		.full_o      (cmd_full),
		.pop_i       (sdr_req_ack_i),
		.pop_data_o  (cmd_head),
		.empty_o     (cmd_empty)
	);

	// request stays up while anything is queued
	assign sdr_req_o      = ~cmd_empty;
	assign sdr_req_wr_n_o = cmd_head[APP_AW];
	assign sdr_req_addr_o = cmd_head[APP_AW-1:0];
	// single transfer, not carried through the queue
	assign sdr_req_len_o  = BL'(BURST_LEN_ONE);

	// ------------------------------------------------------------------------
	// write data queue
	// ------------------------------------------------------------------------
	// byte selects inverted on the way in
	show_ahead_fifo #(.W(WRDAT_W), .DEPTH(WRDAT_DEPTH)) u_wrdatafifo (
		.sdram_clk   (sdram_clk),
		.wb_clk_i    (wb_clk_i),
		.push_i      (wrdat_push),
		.push_data_i ({~wb_sel_i, wb_dat_i}),
		.full_o      (wrdat_full),
		.pop_i       (sdr_wr_next_i),
		.pop_data_o  (wrdat_head),
		.empty_o     (wrdat_empty)
	);

	assign sdr_wr_en_n_o = wrdat_head[WRDAT_W-1:DW];
	assign sdr_wr_data_o = wrdat_head[DW-1:0];

	// ------------------------------------------------------------------------
	// read data queue
	// ------------------------------------------------------------------------
	// never fills with one read in flight, full left open
	show_ahead_fifo #(.W(DW), .DEPTH(RDDAT_DEPTH)) u_rddatafifo (
		.sdram_clk   (sdram_clk),
		.wb_clk_i    (wb_clk_i),
		.push_i      (sdr_rd_valid_i),
		.push_data_i (sdr_rd_data_i),
		.full_o      (),
		.pop_i       (rddat_pop),
		.pop_data_o  (wb_dat_o),
		.empty_o     (rddat_empty)
	);

	// ------------------------------------------------------------------------
	// checks across the queues
	// ------------------------------------------------------------------------
	// a queued write command always has its data word waiting
	a_wr_data_ready: assert property (
		@(posedge sdram_clk) disable iff (wb_clk_i)
		(sdr_req_o && (sdr_req_wr_n_o == SDR_OP_WRITE)) |-> !wrdat_empty
	) else $error("%m write command queued without write data");

	// one read in flight, so returned data lands in an empty queue
	a_rd_data_single: assert property (
		@(posedge sdram_clk) disable iff (wb_clk_i)
		sdr_rd_valid_i |-> rddat_empty
	) else $error("%m read data returned while earlier data unacked");

endmodule

`default_nettype wire

//--- source/wb2sdrc_pkg.sv
`default_nettype none

package wb2sdrc_pkg;

	// ------------------------------------------------------------------------
	// request opcode, encoded the same way as sdr_req_wr_n
	// ------------------------------------------------------------------------
	typedef enum logic {
		SDR_OP_WRITE = 1'b0,
		SDR_OP_READ  = 1'b1
	} sdr_op_e;

	// read tracker, one read in flight at most
	typedef enum logic {
		RD_IDLE    = 1'b0,
		RD_PENDING = 1'b1
	} rd_state_e;

	// ------------------------------------------------------------------------
	// default bus widths
	// ------------------------------------------------------------------------
	// one word of data
	localparam int DEF_DW     = 32;
	// application address, word granular
	localparam int DEF_APP_AW = 26;
	// burst length field towards the controller
	localparam int DEF_BL     = 9;

	// bursts are always a single transfer
	localparam int BURST_LEN_ONE = 1;

	// queue depths in entries
	localparam int CMD_DEPTH   = 4;
	localparam int WRDAT_DEPTH = 8;
	localparam int RDDAT_DEPTH = 4;

endpackage

`default_nettype wire

//--- source/wb_slave_ctrl.sv
`default_nettype none

module wb_slave_ctrl (
	input  logic                 sdram_clk,
	input  logic                 wb_clk_i,

	// wishbone request
	input  logic                 wb_stb_i,
	input  logic                 wb_cyc_i,
	input  logic                 wb_we_i,

	// queue status
	input  logic                 cmd_full_i,
	input  logic                 wrdat_full_i,
	input  logic                 rddat_empty_i,

	// acknowledge and queue strobes
	output logic                 wb_ack_o,
	output logic                 cmd_push_o,
	output wb2sdrc_pkg::sdr_op_e cmd_op_o,
	output logic                 wrdat_push_o,
	output logic                 rddat_pop_o
);

	import wb2sdrc_pkg::*;

	// ------------------------------------------------------------------------
	// request decode
	// ------------------------------------------------------------------------
	logic      wb_req;
	logic      wr_req;
	logic      rd_req;

	// cycle outcomes
	logic      wr_ack;
	logic      rd_ack;
	logic      rd_cmd;

	// read tracker
	rd_state_e rd_state_q;
	rd_state_e rd_state_next;

	// master holds stb and cyc until it sees the ack
	assign wb_req = wb_stb_i & wb_cyc_i;
	assign wr_req = wb_req & wb_we_i;
	assign rd_req = wb_req & ~wb_we_i;

	// ------------------------------------------------------------------------
	// write path
	// ------------------------------------------------------------------------
	// posted write acked as soon as both queues have room
	assign wr_ack = wr_req & ~cmd_full_i & ~wrdat_full_i;

	// ------------------------------------------------------------------------
	// read path
	// ------------------------------------------------------------------------
	// issue the command once per read and only from idle
	assign rd_cmd = rd_req & (rd_state_q == RD_IDLE) & ~cmd_full_i;

	// data back from the controller ends the read
	assign rd_ack = rd_req & ~rddat_empty_i;

	// ------------------------------------------------------------------------
	// combinational outputs
	// ------------------------------------------------------------------------
	assign wb_ack_o     = wr_ack | rd_ack;
	assign cmd_push_o   = wr_ack | rd_cmd;
	assign cmd_op_o     = wb_we_i ? SDR_OP_WRITE : SDR_OP_READ;
	// write data travels with its command
	assign wrdat_push_o = wr_ack;
	// head word goes out on wb_dat_o in the ack cycle
	assign rddat_pop_o  = rd_ack;

	// ------------------------------------------------------------------------
	// pending read tracker
	// ------------------------------------------------------------------------
	always_comb begin
		rd_state_next = rd_state_q;
		// issuing a command takes priority
		if (rd_cmd) begin
			rd_state_next = RD_PENDING;
		end else if (rd_ack) begin
			rd_state_next = RD_IDLE;
		end
	end

	always_ff @(posedge sdram_clk or posedge wb_clk_i) begin
		if (wb_clk_i) begin
			rd_state_q <= RD_IDLE;
		end else begin
			rd_state_q <= rd_state_next;
		end
	end

	// ------------------------------------------------------------------------
	// checks
	// ------------------------------------------------------------------------
	// a second read command never overtakes the first one's data
	a_one_read: assert property (
		@(posedge sdram_clk) disable iff (wb_clk_i)
		(cmd_push_o && (cmd_op_o == SDR_OP_READ)) |-> (rd_state_q == RD_IDLE)
	) else $error("%m read command issued while a read is pending");

endmodule

`default_nettype wire

//--- tb/sdr_ctrl_model.sv
`default_nettype none

module sdr_ctrl_model #(
	parameter int DW = 32,
	parameter int AW = 26
) (
	input  logic            sdram_clk,
	input  logic            wb_clk_i,
	// freezes the model, no command is taken
	input  logic            stall_i,
	input  logic            sdr_req_i,
	input  logic [AW-1:0]   sdr_req_addr_i,
	input  logic            sdr_req_wr_n_i,
	output logic            sdr_req_ack_o,
	input  logic [DW/8-1:0] sdr_wr_en_n_i,
	input  logic [DW-1:0]   sdr_wr_data_i,
	output logic            sdr_wr_next_o,
	output logic            sdr_rd_valid_o,
	output logic [DW-1:0]   sdr_rd_data_o
);

	// small memory, aliases on the low address bits
	logic [DW-1:0] mem [16];
	logic [3:0]    idx;

	assign idx = sdr_req_addr_i[3:0];

	// ------------------------------------------------------------------------
	// one command every other cycle, its pop lands on the following edge
	// ------------------------------------------------------------------------
	always_ff @(posedge sdram_clk or posedge wb_clk_i) begin
		if (wb_clk_i) begin
			sdr_req_ack_o  <= 1'b0;
			sdr_wr_next_o  <= 1'b0;
			sdr_rd_valid_o <= 1'b0;
			sdr_rd_data_o  <= '0;
			for (int i = 0; i < 16; i++) begin
				mem[i] <= DW'(32'h5a3c_0000 ^ (i * 32'h0101_0111));
			end
		end else begin
			// strobes are single cycle pulses
			sdr_req_ack_o  <= 1'b0;
			sdr_wr_next_o  <= 1'b0;
			sdr_rd_valid_o <= 1'b0;
			if (sdr_req_i && !sdr_req_ack_o && !stall_i) begin
				sdr_req_ack_o <= 1'b1;
				if (sdr_req_wr_n_i) begin
					sdr_rd_valid_o <= 1'b1;
					sdr_rd_data_o  <= mem[idx];
				end else begin
					// write data word travels with its command
					sdr_wr_next_o <= 1'b1;
					for (int b = 0; b < DW / 8; b++) begin
						if (!sdr_wr_en_n_i[b]) begin
							mem[idx][8*b +: 8] <= sdr_wr_data_i[8*b +: 8];
						end
					end
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- tb/tb_wb2sdrc.sv
`default_nettype none

module tb_wb2sdrc;

	import wb2sdrc_pkg::*;

	localparam int DW         = DEF_DW;
	localparam int AW         = DEF_APP_AW;
	localparam int BL         = DEF_BL;
	localparam int RST_CYCLES = 4;
	localparam int N_TESTS    = 5;
	// write record holds address then data then active low mask
	localparam int EXP_W      = AW + DW + DW / 8;

	// DUT inputs
	logic            sdram_clk = 1'b0;
	logic            wb_clk_i  = 1'b0;
	logic            wb_stb_i  = 1'b0;
	logic            wb_cyc_i  = 1'b0;
	logic            wb_we_i   = 1'b0;
	logic [AW-1:0]   wb_addr_i = '0;
	logic [DW-1:0]   wb_dat_i  = '0;
	logic [DW/8-1:0] wb_sel_i  = '0;
	logic            stall     = 1'b0;
	logic            sdr_req_ack_i;
	logic            sdr_wr_next_i;
	logic            sdr_rd_valid_i;
	logic [DW-1:0]   sdr_rd_data_i;

	// DUT outputs
	logic            wb_ack_o;
	logic [DW-1:0]   wb_dat_o;
	logic            sdr_req_o;
	logic [AW-1:0]   sdr_req_addr_o;
	logic [BL-1:0]   sdr_req_len_o;
	logic            sdr_req_wr_n_o;
	logic [DW/8-1:0] sdr_wr_en_n_o;
	logic [DW-1:0]   sdr_wr_data_o;

	// scoreboard
	logic [DW-1:0]    mirror [16];
	logic [EXP_W-1:0] exp_wr_q [$];
	logic [AW-1:0]    rd_addr = '0;
	logic [31:0]      rnd     = 32'ha576_db6d;
	int               errors   = 0;
	int               checks   = 0;
	int               err_start = 0;
	int               rd_taken = 0;
	int               rd_acked = 0;
	int               bp_acks  = 0;

	always #5 sdram_clk = ~sdram_clk;

	wb2sdrc #(.DW(DW), .APP_AW(AW), .BL(BL)) UUT (.*);

	sdr_ctrl_model #(.DW(DW), .AW(AW)) u_model (
		.sdram_clk      (sdram_clk),
		.wb_clk_i       (wb_clk_i),
		.stall_i        (stall),
		.sdr_req_i      (sdr_req_o),
		.sdr_req_addr_i (sdr_req_addr_o),
		.sdr_req_wr_n_i (sdr_req_wr_n_o),
		.sdr_req_ack_o  (sdr_req_ack_i),
		.sdr_wr_en_n_i  (sdr_wr_en_n_o),
		.sdr_wr_data_i  (sdr_wr_data_o),
		.sdr_wr_next_o  (sdr_wr_next_i),
		.sdr_rd_valid_o (sdr_rd_valid_i),
		.sdr_rd_data_o  (sdr_rd_data_i)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic report_error(input string msg);
		$display("** Error at %0t: %s", $time, msg);
		errors++;
	endtask

	task automatic report_test(input int num, input string name);
		$display("test %0d %s finished, %0d errors", num, name, errors - err_start);
		err_start = errors;
	endtask

	// ------------------------------------------------------------------------
	// wishbone master holding its request until the ack
	// ------------------------------------------------------------------------
	task automatic wb_cycle(input logic we, input logic [AW-1:0] addr,
			input logic [DW-1:0] data, input logic [DW/8-1:0] sel);
		@(posedge sdram_clk);
		if (!we) begin
			rd_addr <= addr;
		end
		wb_stb_i  <= 1'b1;
		wb_cyc_i  <= 1'b1;
		wb_we_i   <= we;
		wb_addr_i <= addr;
		wb_dat_i  <= data;
		wb_sel_i  <= sel;
		@(posedge sdram_clk);
		while (!wb_ack_o) @(posedge sdram_clk);
		wb_stb_i <= 1'b0;
		wb_cyc_i <= 1'b0;
	endtask

	task automatic random_write(input logic [3:0] idx, input logic [DW/8-1:0] sel);
		logic [AW-1:0] addr;
		rnd = xorshift32(rnd);
		addr = {rnd[AW-1:4], idx};
		rnd = xorshift32(rnd);
		wb_cycle(1'b1, addr, rnd, sel);
	endtask

	task automatic random_read(input logic [3:0] idx);
		rnd = xorshift32(rnd);
		wb_cycle(1'b0, {rnd[AW-1:4], idx}, '0, '0);
	endtask

	// queue empty and every write taken by the model
	task automatic wait_drained();
		@(posedge sdram_clk);
		while (sdr_req_o || exp_wr_q.size() != 0) @(posedge sdram_clk);
	endtask

	// ------------------------------------------------------------------------
	// monitor with mirror memory and command compare
	// ------------------------------------------------------------------------
	always @(posedge sdram_clk) begin
		logic [EXP_W-1:0] wr_rec;
		if (!wb_clk_i) begin
			if (wb_ack_o && wb_we_i) begin
				for (int b = 0; b < DW / 8; b++) begin
					if (wb_sel_i[b]) begin
						mirror[wb_addr_i[3:0]][8*b +: 8] = wb_dat_i[8*b +: 8];
					end
				end
				exp_wr_q.push_back({wb_addr_i, wb_dat_i, ~wb_sel_i});
				if (stall) begin
					bp_acks++;
				end
			end
			if (wb_ack_o && !wb_we_i) begin
				checks++;
				rd_acked++;
				assert (wb_dat_o == mirror[rd_addr[3:0]])
				else report_error($sformatf("read %h got %h expected %h",
						rd_addr, wb_dat_o, mirror[rd_addr[3:0]]));
			end
			if (sdr_req_o && sdr_req_ack_i) begin
				checks++;
				assert (sdr_req_len_o == BL'(BURST_LEN_ONE))
				else report_error($sformatf("burst length %0d", sdr_req_len_o));
				if (sdr_req_wr_n_o == SDR_OP_READ) begin
					rd_taken++;
					assert (sdr_req_addr_o == rd_addr)
					else report_error($sformatf("read command address %h", sdr_req_addr_o));
				end else if (exp_wr_q.size() == 0) begin
					report_error("write command without a matching wishbone write");
				end else begin
					wr_rec = exp_wr_q.pop_front();
					assert (sdr_wr_next_i && sdr_req_addr_o == wr_rec[EXP_W-1 -: AW] &&
							sdr_wr_data_o == wr_rec[DW/8 +: DW] &&
							sdr_wr_en_n_o == wr_rec[DW/8-1:0])
					else report_error($sformatf("write got %h/%h/%h expected %h",
							sdr_req_addr_o, sdr_wr_data_o, sdr_wr_en_n_o, wr_rec));
				end
			end
		end
	end

	// ------------------------------------------------------------------------
	// protocol properties
	// ------------------------------------------------------------------------
	a_reset_quiet: assert property (@(posedge sdram_clk)
		(wb_clk_i || $past(wb_clk_i)) |-> (!wb_ack_o && !sdr_req_o))
	else report_error("ack or request active around reset");

	a_one_read_out: assert property (@(posedge sdram_clk) disable iff (wb_clk_i)
		rd_taken <= rd_acked + 1)
	else report_error($sformatf("%0d read commands for %0d acks", rd_taken, rd_acked));

	// stalled model fills the command queue and holds the master off
	a_bp_hold: assert property (@(posedge sdram_clk) disable iff (wb_clk_i)
		(stall && bp_acks >= CMD_DEPTH) |-> (sdr_req_o && !wb_ack_o))
	else report_error("write acked or request dropped with the command queue full");

	a_bp_count: assert property (@(posedge sdram_clk) disable iff (wb_clk_i)
		$fell(stall) |-> (bp_acks == CMD_DEPTH))
	else report_error($sformatf("%0d write acks while stalled", bp_acks));

	// ------------------------------------------------------------------------
	// tests
	// ------------------------------------------------------------------------
	initial begin
		// assert reset at time zero
		wb_clk_i <= 1'b1;
		repeat (RST_CYCLES) @(posedge sdram_clk);
		wb_clk_i <= 1'b0;
		repeat (2) @(posedge sdram_clk);
		report_test(1, "reset");

		// fill every word with all bytes selected
		for (int i = 0; i < 16; i++) begin
			random_write(4'(i), '1);
		end
		wait_drained();
		report_test(2, "write capture");

		for (int i = 0; i < 8; i++) begin
			rnd = xorshift32(rnd);
			random_write(rnd[3:0], rnd[7:4]);
		end
		for (int i = 0; i < 16; i++) begin
			random_read(4'(i));
		end
		wait_drained();
		report_test(3, "read round trip");

		// mixed stream including back to back reads
		for (int i = 0; i < 16; i++) begin
			rnd = xorshift32(rnd);
			if (rnd[0]) begin
				random_write(rnd[4:1], rnd[8:5]);
			end else begin
				random_read(rnd[4:1]);
			end
		end
		wait_drained();
		report_test(4, "single outstanding read");

		@(posedge sdram_clk);
		bp_acks = 0;
		stall <= 1'b1;
		fork
			begin
				for (int k = 0; k < CMD_DEPTH + 3; k++) begin
					random_write(4'(k), '1);
				end
			end
			begin
				// observation window longer than filling the queue
				repeat (3 * CMD_DEPTH + 8) @(posedge sdram_clk);
				stall <= 1'b0;
			end
		join
		wait_drained();
		report_test(5, "back-pressure");

		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

	// ends a run in which a handshake never completes
	initial begin
		repeat (RST_CYCLES + 200 * N_TESTS) @(posedge sdram_clk);
		$display("watchdog expired before the tests completed");
		$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire
